/* Makefile */
SRCS = $(shell cat revo_receiver.f)

all: run

obj_dir/Vtb_revo_receiver: revo_receiver.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_revo_receiver -f revo_receiver.f -o Vtb_revo_receiver

sim.log: obj_dir/Vtb_revo_receiver
	./obj_dir/Vtb_revo_receiver > sim.log 2>&1 || true

run: sim.log
	cat sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* revo_receiver.f */
src/revo_pkg.sv
src/revo_decoder.sv
src/bucket_counter.sv
src/bunch_marker_match.sv
src/trigger_prescaler.sv
src/revo_receiver_top.sv
verif/revo_receiver_checker.sv
verif/tb_revo_receiver.sv

/* src/bucket_counter.sv */
`timescale 1ns/1ps

module bucket_counter #(
	parameter int BUCKETS_PER_REVO = 40
) (
	input  logic                                  clock127,
	input  logic                                  rst_n,
	input  logic                                  revo,
	output logic [revo_pkg::BUCKET_WIDTH-1:0]     bucket,
	output logic [revo_pkg::REVO_INDEX_WIDTH-1:0] revo_index,
	output logic                                  frame,
	output logic                                  frame9
);

	localparam int BW = revo_pkg::BUCKET_WIDTH;
	localparam int RW = revo_pkg::REVO_INDEX_WIDTH;

	localparam logic [BW-1:0] LAST_BUCKET = BW'(BUCKETS_PER_REVO - 1);
	localparam logic [RW-1:0] LAST_REVO = RW'(revo_pkg::REVOS_PER_FRAME - 1);

	logic started; // first revo since reset aligns the frame

	always_ff @(posedge clock127) begin
		if (!rst_n) begin
			bucket     <= '0;
			revo_index <= '0;
			frame      <= 1'b0;
			frame9     <= 1'b0;
			started    <= 1'b0;
		end else begin
			frame  <= revo;
			frame9 <= 1'b0;
			if (revo) begin
				bucket  <= '0;
				started <= 1'b1;
				if (!started || revo_index == LAST_REVO) begin
					revo_index <= '0;
					frame9     <= 1'b1;
				end else begin
					revo_index <= revo_index + 1'b1;
				end
			end else if (bucket == LAST_BUCKET) begin
				bucket <= '0; // free-running wrap, no frame
			end else begin
				bucket <= bucket + 1'b1;
			end
		end
	end

endmodule

/* src/bunch_marker_match.sv */
`timescale 1ns/1ps

module bunch_marker_match (
	input  logic                                  clock127,
	input  logic                                  rst_n,
	input  logic [revo_pkg::BUCKET_WIDTH-1:0]     bucket,
	input  logic [revo_pkg::REVO_INDEX_WIDTH-1:0] revo_index,
	input  revo_pkg::bunch_marker_t               marker_a,
	input  revo_pkg::bunch_marker_t               marker_b,
	input  revo_pkg::bunch_marker_t               marker_c,
	input  revo_pkg::bunch_marker_t               marker_d,
	output logic                                  hit
);

	revo_pkg::bunch_marker_t          markers [revo_pkg::NUM_MARKERS];
	logic [revo_pkg::NUM_MARKERS-1:0] match;

	assign markers[0] = marker_a;
	assign markers[1] = marker_b;
	assign markers[2] = marker_c;
	assign markers[3] = marker_d;

	// position match gated by the revolution mask
	always_comb begin
		for (int i = 0; i < revo_pkg::NUM_MARKERS; i++) begin
			match[i] = (markers[i].fields.bucket == bucket)
				&& markers[i].fields.frame_mask[revo_index];
		end
	end

	always_ff @(posedge clock127) begin
		if (!rst_n)
			hit <= 1'b0;
		else
			hit <= |match; // overlapping markers give one hit
	end

endmodule

/* src/revo_decoder.sv */
`timescale 1ns/1ps

// trg36 toggles every clock; one missing toggle marks the revolution.
// a run of three equal samples means the link is gone
module revo_decoder (
	input  logic clock127,
	input  logic rst_n,
	input  logic trg36,
	output logic revo,
	output logic locked
);

	logic trg_q1;     // previous sample
	logic trg_q2;     // sample before that
	logic stuck;      // last edge saw three equal samples
	logic repeat_new; // incoming sample equals previous
	logic repeat_old; // previous pair was already a repeat
	logic clean_revo;

	assign repeat_new = (trg36 == trg_q1);
	assign repeat_old = (trg_q1 == trg_q2);

	// single repeat, toggling resumed, and not the tail of a longer run
	assign clean_revo = repeat_old && !repeat_new && !stuck;

	always_ff @(posedge clock127) begin
		trg_q1 <= trg36;
		trg_q2 <= trg_q1;
	end

	always_ff @(posedge clock127) begin
		if (!rst_n) begin
			revo   <= 1'b0;
			locked <= 1'b0;
			stuck  <= 1'b1; // no clean history yet
		end else begin
			revo  <= clean_revo;
			stuck <= repeat_old && repeat_new;
			if (stuck)
				locked <= 1'b0; // double repeat, link lost
			else if (clean_revo)
				locked <= 1'b1;
		end
	end

endmodule

/* src/revo_pkg.sv */
package revo_pkg;

	// bucket index within one revolution, up to 2048 buckets
	localparam int BUCKET_WIDTH = 11;

	// revolutions in one frame9 period
	localparam int REVOS_PER_FRAME = 9;
	localparam int REVO_INDEX_WIDTH = 4;

	localparam int NUM_MARKERS = 4;

	// trigger prescale exponent, 2**N hits per trigger
	localparam int PRESCALE_WIDTH = 5;

	localparam int MARKER_WIDTH = 25;

	// decoded view of one marker word, high bit first
	typedef struct packed {
		logic [REVOS_PER_FRAME-1:0] frame_mask; // bit k fires in revolution k
		logic [2:0]                 spare_hi;
		logic [BUCKET_WIDTH-1:0]    bucket;
		logic [1:0]                 spare_lo;
	} bunch_marker_fields_t;

	// same 25 bits seen as a config word or as fields
	typedef union packed {
		logic [MARKER_WIDTH-1:0] raw;
		bunch_marker_fields_t    fields;
	} bunch_marker_t;

endpackage

/* src/revo_receiver_top.sv */
`timescale 1ns/1ps

module revo_receiver_top #(
	parameter int BUCKETS_PER_REVO = 40
) (
	input  logic                                clock127,
	input  logic                                rst_n,
	input  logic                                trg36,
	input  logic                                trigger_enabled,
	input  logic [revo_pkg::PRESCALE_WIDTH-1:0] prescale_log2,
	input  revo_pkg::bunch_marker_t             marker_a,
	input  revo_pkg::bunch_marker_t             marker_b,
	input  revo_pkg::bunch_marker_t             marker_c,
	input  revo_pkg::bunch_marker_t             marker_d,
	output logic                                xrm_trigger,
	output logic                                frame,
	output logic                                frame9,
	output logic                                locked
);

	logic                                  revo;
	logic [revo_pkg::BUCKET_WIDTH-1:0]     bucket;
	logic [revo_pkg::REVO_INDEX_WIDTH-1:0] revo_index;
	logic                                  hit;

	revo_decoder i_revo_decoder (
		.clock127 (clock127),
		.rst_n    (rst_n),
		.trg36    (trg36),
		.revo     (revo),
		.locked   (locked)
	);

	bucket_counter #(
		.BUCKETS_PER_REVO (BUCKETS_PER_REVO)
	) i_bucket_counter (
		.clock127   (clock127),
		.rst_n      (rst_n),
		.revo       (revo),
		.bucket     (bucket),
		.revo_index (revo_index),
		.frame      (frame),
		.frame9     (frame9)
	);

	bunch_marker_match i_bunch_marker_match (
		.clock127   (clock127),
		.rst_n      (rst_n),
		.bucket     (bucket),
		.revo_index (revo_index),
		.marker_a   (marker_a),
		.marker_b   (marker_b),
		.marker_c   (marker_c),
		.marker_d   (marker_d),
		.hit        (hit)
	);

	trigger_prescaler i_trigger_prescaler (
		.clock127        (clock127),
		.rst_n           (rst_n),
		.hit             (hit),
		.trigger_enabled (trigger_enabled),
		.prescale_log2   (prescale_log2),
		.xrm_trigger     (xrm_trigger)
	);

endmodule

/* src/trigger_prescaler.sv */
`timescale 1ns/1ps

module trigger_prescaler (
	input  logic                                clock127,
	input  logic                                rst_n,
	input  logic                                hit,
	input  logic                                trigger_enabled,
	input  logic [revo_pkg::PRESCALE_WIDTH-1:0] prescale_log2,
	output logic                                xrm_trigger
);

	localparam int PW = revo_pkg::PRESCALE_WIDTH;
	localparam int COUNT_WIDTH = 16;
	localparam logic [PW-1:0] MAX_LOG2 = PW'(COUNT_WIDTH);

	logic [COUNT_WIDTH-1:0] count;
	logic [COUNT_WIDTH-1:0] count_next;
	logic [PW-1:0]          exp_capped;
	logic [COUNT_WIDTH-1:0] low_mask; // low exp_capped bits set

	assign count_next = count + 1'b1;
	assign exp_capped = (prescale_log2 > MAX_LOG2) ? MAX_LOG2 : prescale_log2;
	assign low_mask   = {COUNT_WIDTH{1'b1}} >> (MAX_LOG2 - exp_capped);

	always_ff @(posedge clock127) begin
		if (!rst_n) begin
			count       <= '0;
			xrm_trigger <= 1'b0;
		end else if (!trigger_enabled) begin
			count       <= '0; // disabled, start over
			xrm_trigger <= 1'b0;
		end else begin
			// fire when the new count is a multiple of 2**N
			xrm_trigger <= hit && ((count_next & low_mask) == '0);
			if (hit)
				count <= count_next;
		end
	end

endmodule

/* verif/revo_receiver_checker.sv */
`timescale 1ns/1ps

module revo_receiver_checker (
	input logic clock127,
	input logic rst_n,
	input logic revo,
	input logic locked,
	input logic frame,
	input logic frame9,
	input logic xrm_trigger,
	input logic trigger_enabled
);

	logic seen_revo; // a revo has arrived since reset

	always_ff @(posedge clock127) begin
		if (!rst_n)
			seen_revo <= 1'b0;
		else if (revo)
			seen_revo <= 1'b1;
	end

	// a revo is a single missing toggle, never two cycles long
	revo_single_cycle: assert property (@(posedge clock127) disable iff (!rst_n)
		revo |=> !revo)
		else $error("revo strobe high on two consecutive cycles");

	frame9_with_frame: assert property (@(posedge clock127) disable iff (!rst_n)
		frame9 |-> frame)
		else $error("frame9 high without frame");

	no_trigger_disabled: assert property (@(posedge clock127) disable iff (!rst_n)
		(!$past(trigger_enabled) && !$past(trigger_enabled, 2)) |-> !xrm_trigger)
		else $error("xrm_trigger high while trigger_enabled was low");

	// locked rises together with the first revo
	locked_after_revo: assert property (@(posedge clock127) disable iff (!rst_n)
		!seen_revo |-> (!locked || revo))
		else $error("locked high before the first revo");

endmodule

/* verif/tb_revo_receiver.sv */
`timescale 1ns/1ps

module tb_revo_receiver;

	localparam int BUCKETS = 40;
	localparam int NUM_ROWS = 7;
	localparam int MW = revo_pkg::MARKER_WIDTH;

	typedef struct packed {
		logic [MW-1:0]                       mark_a;
		logic [MW-1:0]                       mark_b;
		logic [MW-1:0]                       mark_c;
		logic [MW-1:0]                       mark_d;
		logic [revo_pkg::PRESCALE_WIDTH-1:0] prescale;
		logic                                enable;
		logic [7:0]                          revs;
		logic                                link_loss;
	} case_t;

	logic                                clock127;
	logic                                rst_n;
	logic                                trg36;
	logic                                trigger_enabled;
	logic [revo_pkg::PRESCALE_WIDTH-1:0] prescale_log2;
	revo_pkg::bunch_marker_t             marker_a;
	revo_pkg::bunch_marker_t             marker_b;
	revo_pkg::bunch_marker_t             marker_c;
	revo_pkg::bunch_marker_t             marker_d;
	logic                                xrm_trigger;
	logic                                frame;
	logic                                frame9;
	logic                                locked;

	case_t       cases [NUM_ROWS];
	logic        trg_last;   // level last driven on the line
	logic        rep_line;   // line value equals the one before
	logic [31:0] lcg_state;
	logic        check_on = 1'b0;
	int          errors = 0;
	int          checks = 0;
	int          triggers = 0;
	int          cycles = 0;
	int          cycle_limit = 0;

	// reference model state
	logic m_prev_rep = 1'b0;
	logic m_stuck = 1'b1;
	logic m_revo = 1'b0;
	logic m_locked = 1'b0;
	logic m_started = 1'b0;
	logic m_frame = 1'b0;
	logic m_frame9 = 1'b0;
	logic m_hit = 1'b0;
	logic m_xrm = 1'b0;
	int   m_bucket = 0;
	int   m_revo_index = 0;
	int   m_count = 0;

	revo_receiver_top #(
		.BUCKETS_PER_REVO (BUCKETS)
	) i_revo_receiver_top (
		.clock127        (clock127),
		.rst_n           (rst_n),
		.trg36           (trg36),
		.trigger_enabled (trigger_enabled),
		.prescale_log2   (prescale_log2),
		.marker_a        (marker_a),
		.marker_b        (marker_b),
		.marker_c        (marker_c),
		.marker_d        (marker_d),
		.xrm_trigger     (xrm_trigger),
		.frame           (frame),
		.frame9          (frame9),
		.locked          (locked)
	);

	bind revo_receiver_top revo_receiver_checker i_revo_receiver_checker (
		.clock127        (clock127),
		.rst_n           (rst_n),
		.revo            (revo),
		.locked          (locked),
		.frame           (frame),
		.frame9          (frame9),
		.xrm_trigger     (xrm_trigger),
		.trigger_enabled (trigger_enabled)
	);

	initial begin
		clock127 = 1'b0;
		forever #5 clock127 = ~clock127;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// mask, spare, bucket, spare from the top bit down
	function automatic logic [MW-1:0] marker_word(
		input logic [revo_pkg::REVOS_PER_FRAME-1:0] mask,
		input logic [revo_pkg::BUCKET_WIDTH-1:0]    bucket
	);
		return {mask, 3'b000, bucket, 2'b00};
	endfunction

	function automatic logic [MW-1:0] random_marker();
		logic [revo_pkg::BUCKET_WIDTH-1:0]    bucket;
		logic [revo_pkg::REVOS_PER_FRAME-1:0] mask;
		bucket = 11'((lcg_next() >> 16) % 32'd40); // legal buckets only
		mask = 9'(lcg_next() >> 20);
		return marker_word(mask, bucket);
	endfunction

	function automatic case_t make_case(
		input logic [MW-1:0]                       a,
		input logic [MW-1:0]                       b,
		input logic [MW-1:0]                       c,
		input logic [MW-1:0]                       d,
		input logic [revo_pkg::PRESCALE_WIDTH-1:0] prescale,
		input logic                                enable,
		input int                                  revs,
		input logic                                link_loss
	);
		case_t row;
		row.mark_a = a;
		row.mark_b = b;
		row.mark_c = c;
		row.mark_d = d;
		row.prescale = prescale;
		row.enable = enable;
		row.revs = 8'(revs);
		row.link_loss = link_loss;
		return row;
	endfunction

	task automatic build_table();
		// all-ones, single bits and an empty mask
		cases[0] = make_case(marker_word(9'h1ff, 11'd5), marker_word(9'h001, 11'd12),
			marker_word(9'h010, 11'd20), marker_word(9'h000, 11'd30), 5'd0, 1'b1, 10, 1'b0);
		// two markers on one bucket
		cases[1] = make_case(marker_word(9'h1ff, 11'd17), marker_word(9'h1ff, 11'd17),
			marker_word(9'h100, 11'd39), marker_word(9'h008, 11'd0), 5'd0, 1'b1, 9, 1'b0);
		cases[2] = make_case(marker_word(9'h1ff, 11'd3), marker_word(9'h1ff, 11'd25),
			marker_word(9'h000, 11'd0), marker_word(9'h000, 11'd0), 5'd2, 1'b1, 9, 1'b0);
		cases[3] = make_case(marker_word(9'h1ff, 11'd8), marker_word(9'h1ff, 11'd21),
			marker_word(9'h1ff, 11'd33), marker_word(9'h000, 11'd0), 5'd3, 1'b1, 8, 1'b0);
		cases[4] = make_case(marker_word(9'h1ff, 11'd8), marker_word(9'h1ff, 11'd21),
			marker_word(9'h1ff, 11'd33), marker_word(9'h000, 11'd0), 5'd1, 1'b0, 4, 1'b0);
		// count restarts from zero after the disabled row
		cases[5] = make_case(random_marker(), random_marker(), random_marker(),
			random_marker(), 5'd2, 1'b1, 6, 1'b1);
		cases[6] = make_case(random_marker(), random_marker(), random_marker(),
			random_marker(), 5'd1, 1'b1, 6, 1'b0);
	endtask

	// one clock of line as a toggle or a repeat
	task automatic step_line(input logic rep);
		if (!rep)
			trg_last = ~trg_last;
		trg36 <= trg_last;
		rep_line <= rep;
	endtask

	task automatic run_row(input int row);
		int   revs;
		logic rep;
		revs = int'(cases[row].revs);
		for (int r = 0; r < revs; r++) begin
			for (int c = 0; c < BUCKETS; c++) begin
				@(posedge clock127);
				if (r == 0 && c == 0) begin
					marker_a <= cases[row].mark_a;
					marker_b <= cases[row].mark_b;
					marker_c <= cases[row].mark_c;
					marker_d <= cases[row].mark_d;
					prescale_log2 <= cases[row].prescale;
					trigger_enabled <= cases[row].enable;
				end
				rep = (c == 0) || (c == 1 && cases[row].link_loss && r == revs / 2);
				step_line(rep);
			end
		end
	endtask

	function automatic logic marker_hits(input logic [MW-1:0] word, input int bucket,
		input int idx);
		logic [revo_pkg::REVOS_PER_FRAME-1:0] mask;
		mask = word[MW-1 -: revo_pkg::REVOS_PER_FRAME];
		return (int'(word[2 +: revo_pkg::BUCKET_WIDTH]) == bucket) && mask[idx];
	endfunction

	function automatic int prescale_period(input logic [revo_pkg::PRESCALE_WIDTH-1:0] exp);
		int n;
		n = int'(exp);
		if (n > 16)
			n = 16;
		return 1 << n;
	endfunction

	// later stages first so each reads last cycle's state
	always @(posedge clock127) begin : ref_model
		logic rep_now;
		logic revo_next;
		rep_now = rep_line;
		if (!rst_n || !trigger_enabled) begin
			m_xrm = 1'b0;
			m_count = 0;
		end else begin
			m_xrm = m_hit && ((m_count + 1) % prescale_period(prescale_log2) == 0);
			if (m_hit)
				m_count = m_count + 1;
		end
		m_hit = rst_n && (marker_hits(marker_a.raw, m_bucket, m_revo_index)
			|| marker_hits(marker_b.raw, m_bucket, m_revo_index)
			|| marker_hits(marker_c.raw, m_bucket, m_revo_index)
			|| marker_hits(marker_d.raw, m_bucket, m_revo_index));
		if (!rst_n) begin
			m_frame = 1'b0;
			m_frame9 = 1'b0;
			m_bucket = 0;
			m_revo_index = 0;
			m_started = 1'b0;
		end else begin
			m_frame = m_revo;
			m_frame9 = m_revo && (!m_started || m_revo_index == revo_pkg::REVOS_PER_FRAME - 1);
			if (m_revo) begin
				m_revo_index = m_frame9 ? 0 : m_revo_index + 1;
				m_bucket = 0;
				m_started = 1'b1;
			end else begin
				m_bucket = (m_bucket + 1) % BUCKETS; // wrap without a frame
			end
		end
		if (!rst_n) begin
			m_revo = 1'b0;
			m_locked = 1'b0;
			m_stuck = 1'b1;
		end else begin
			revo_next = m_prev_rep && !rep_now && !m_stuck;
			if (m_stuck)
				m_locked = 1'b0;
			else if (revo_next)
				m_locked = 1'b1;
			m_stuck = m_prev_rep && rep_now; // three equal samples
			m_revo = revo_next;
		end
		m_prev_rep = rep_now;
	end

	task automatic check_strobe(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH time=%0t %s got=%b expected=%b", $time, name, got, exp);
		end
	endtask

	task automatic check_locked(input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH time=%0t locked got=%b expected=%b", $time, got, exp);
		end
	endtask

	always @(negedge clock127) begin
		if (check_on) begin
			check_strobe("frame", frame, m_frame);
			check_strobe("frame9", frame9, m_frame9);
			check_strobe("xrm_trigger", xrm_trigger, m_xrm);
			check_locked(locked, m_locked);
			if (m_xrm)
				triggers++;
		end
	end

	always @(posedge clock127) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Verification failed");
			$finish;
		end
	end

	initial begin
		rst_n = 1'b0;
		trg36 = 1'b0;
		trg_last = 1'b0;
		rep_line = 1'b0;
		trigger_enabled = 1'b0;
		prescale_log2 = '0;
		marker_a = '0;
		marker_b = '0;
		marker_c = '0;
		marker_d = '0;
		lcg_state = 32'd54;
		build_table();
		cycle_limit = 100;
		for (int i = 0; i < NUM_ROWS; i++)
			cycle_limit += BUCKETS * int'(cases[i].revs);

		repeat (8) begin
			@(posedge clock127);
			step_line(1'b0); // line toggles through reset
		end
		rst_n <= 1'b1;
		check_on = 1'b1;
		repeat (4) begin
			@(posedge clock127);
			step_line(1'b0);
		end

		for (int row = 0; row < NUM_ROWS; row++)
			run_row(row);

		repeat (12) begin
			@(posedge clock127);
			step_line(1'b0);
		end
		@(negedge clock127);
		#1;

		if (triggers == 0)
			$display("no trigger was predicted, the table exercised no marker");
		$display("checks %0d, errors %0d, predicted triggers %0d", checks, errors, triggers);
		if (errors == 0 && triggers > 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule
